/* build.f */
chess_pkg.sv
square_probe.sv
move_scan_fsm.sv
move_builder.sv
move_store.sv
move_gen_top.sv
tb_move_model.sv
tb_move_gen.sv

/* tb_move_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_move_gen
   import chess_pkg::*, tb_move_model::*;
();

   logic                        clk;
   logic                        reset;
   logic                        board_valid;
   board_t                      board_in;
   logic                        white_to_move_in;
   logic                        clear_moves;
   logic [MOVE_INDEX_WIDTH-1:0] move_index;
   logic                        moves_ready;
   logic [MOVE_COUNT_WIDTH-1:0] move_count;
   board_t                      board_out;
   logic                        white_to_move_out;

   int   count_errors = 0;
   int   board_errors = 0;
   int   side_errors = 0;
   int   other_errors = 0;
   logic timed_out = 1'b0;

   move_gen_top i_move_gen_top (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .board_in          (board_in),
      .white_to_move_in  (white_to_move_in),
      .clear_moves       (clear_moves),
      .move_index        (move_index),
      .moves_ready       (moves_ready),
      .move_count        (move_count),
      .board_out         (board_out),
      .white_to_move_out (white_to_move_out)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   task automatic check_count(input logic [MOVE_COUNT_WIDTH-1:0] got,
                              input logic [MOVE_COUNT_WIDTH-1:0] exp);
      if (got !== exp)
      begin
         $display("Mismatch move_count: got %h, expected %h", got, exp);
         count_errors++;
      end
   endtask

   task automatic check_board(input int idx, input board_t got, input board_t exp);
      if (got !== exp)
      begin
         $display("Mismatch board_out[%0d]: got %h, expected %h", idx, got, exp);
         board_errors++;
      end
   endtask

   task automatic check_side(input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Mismatch white_to_move_out: got %h, expected %h", got, exp);
         side_errors++;
      end
   endtask

   function automatic board_t random_position();
      board_t b;
      piece_t kinds [6];
      int     n;
      int     placed;
      int     s;
      kinds = '{KNIGHT, BISHOP, ROOK, QUEEN, KING, PAWN};
      b = '0;
      n = 2 + $urandom % 9;
      placed = 0;
      while (placed < n)
      begin
         s = $urandom % 64;
         if (square_of(b, square_t'(s)) == '0)
         begin
            b[s*PIECE_WIDTH +: PIECE_WIDTH] = {1'($urandom % 2), kinds[$urandom % 6]};
            placed++;
         end
      end
      return b;
   endfunction

   // load, wait for the scan, read every entry back, then clear
   task automatic run_position(input board_t b, input logic white);
      board_t exp_moves [$];
      int     cycles;
      int     i;
      expected_moves(b, white, exp_moves);
      @(posedge clk);
      #1;
      board_in = b;
      white_to_move_in = white;
      board_valid = 1'b1;
      @(posedge clk);
      #1;
      board_valid = 1'b0;
      cycles = 0;
      while (!moves_ready && cycles < 20000)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!moves_ready)
      begin
         $display("Timeout: moves_ready did not rise after a board was loaded");
         other_errors++;
         timed_out = 1'b1;
      end
      else
      begin
         check_count(move_count, MOVE_COUNT_WIDTH'(exp_moves.size()));
         check_side(white_to_move_out, ~white);
         for (i = 0; i < exp_moves.size(); i++)
         begin
            move_index = MOVE_INDEX_WIDTH'(i);
            @(posedge clk);
            #1; // read data registered
            check_board(i, board_out, exp_moves[i]);
         end
         clear_moves = 1'b1;
         @(posedge clk);
         #1;
         clear_moves = 1'b0;
         cycles = 0;
         while (moves_ready && cycles < 10)
         begin
            @(posedge clk);
            #1;
            cycles++;
         end
         if (moves_ready)
         begin
            $display("Timeout: moves_ready stayed high after clear_moves");
            other_errors++;
            timed_out = 1'b1;
         end
      end
   endtask

   initial
   begin
      board_t b;
      int     t;
      void'($urandom(27));
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      white_to_move_in = 1'b1;
      clear_moves = 1'b0;
      move_index = '0;
      repeat (8)
         @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (3)
         @(posedge clk);
      #1;
      if (moves_ready !== 1'b0)
      begin
         $display("moves_ready is high after reset with no board loaded");
         other_errors++;
      end

      b = '0;
      b[0*PIECE_WIDTH +: PIECE_WIDTH] = 4'h4; // white rook
      b[3*PIECE_WIDTH +: PIECE_WIDTH] = 4'ha; // black knight stops the slide
      b[27*PIECE_WIDTH +: PIECE_WIDTH] = 4'h6; // white king
      run_position(b, 1'b1);

      b = '0;
      b[4*PIECE_WIDTH +: PIECE_WIDTH] = 4'he; // black pieces only
      b[63*PIECE_WIDTH +: PIECE_WIDTH] = 4'hc;
      if (!timed_out)
         run_position(b, 1'b1);

      b = '0;
      for (t = 8; t < 16; t++)
         b[t*PIECE_WIDTH +: PIECE_WIDTH] = 4'h1; // white pawns only
      b[60*PIECE_WIDTH +: PIECE_WIDTH] = 4'he;
      if (!timed_out)
         run_position(b, 1'b1);

      for (t = 0; t < 40 && !timed_out; t++)
      begin
         b = random_position();
         run_position(b, 1'b1);
         if (!timed_out)
            run_position(b, 1'b0);
      end

      $display("errors: count %0d, board %0d, side %0d, other %0d",
               count_errors, board_errors, side_errors, other_errors);
      if (count_errors + board_errors + side_errors + other_errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb_move_model.sv */
`default_nettype none

package tb_move_model;

   import chess_pkg::*;

   // ordered result boards for the side to move, first MAX_MOVES kept
   function automatic void expected_moves(input board_t b, input logic white,
                                          ref board_t moves [$]);
      logic [PIECE_WIDTH-1:0] p;
      logic [PIECE_WIDTH-1:0] t;
      piece_t                 kind;
      board_t                 nb;
      logic                   slide;
      int                     s;
      int                     d;
      int                     ndir;
      int                     r;
      int                     c;
      int                     dr;
      int                     dc;
      moves.delete();
      for (s = 0; s < 64; s++)
      begin
         p = square_of(b, square_t'(s));
         kind = piece_t'(p[2:0]);
         if (p == '0 || kind == PAWN || p[BLACK_BIT] == white)
            continue; // empty, pawn or opponent
         ndir = (kind == ROOK || kind == BISHOP) ? 4 : 8;
         slide = (kind == ROOK || kind == BISHOP || kind == QUEEN);
         for (d = 0; d < ndir; d++)
         begin
            dr = dir_offset(kind, 3'(d), 1'b0);
            dc = dir_offset(kind, 3'(d), 1'b1);
            r = s / 8 + dr;
            c = s % 8 + dc;
            while (r >= 0 && r < 8 && c >= 0 && c < 8)
            begin
               t = square_of(b, square_t'(r * 8 + c));
               if (t != '0 && t[BLACK_BIT] != white)
                  break; // own piece blocks
               nb = b;
               nb[s*PIECE_WIDTH +: PIECE_WIDTH] = '0;
               nb[(r*8+c)*PIECE_WIDTH +: PIECE_WIDTH] = p;
               if (moves.size() < MAX_MOVES)
                  moves.push_back(nb);
               if (t != '0 || !slide)
                  break; // capture ends the slide
               r = r + dr;
               c = c + dc;
            end
         end
      end
   endfunction

endpackage

`default_nettype wire

/* move_gen_top.sv */
`timescale 1ns/100ps
`default_nettype none

module move_gen_top
   import chess_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        board_valid,
   input  board_t                      board_in,
   input  logic                        white_to_move_in,
   input  logic                        clear_moves,
   input  logic [MOVE_INDEX_WIDTH-1:0] move_index,
   output logic                        moves_ready,
   output logic [MOVE_COUNT_WIDTH-1:0] move_count,
   output board_t                      board_out,
   output logic                        white_to_move_out
);

   board_t                 board;
   logic                   white_to_move;
   logic                   start;
   logic                   cand_valid;
   square_t                from_sq;
   square_t                to_sq;
   logic [PIECE_WIDTH-1:0] piece;
   logic                   wr;
   board_t                 wr_board;

   move_scan_fsm i_move_scan_fsm (
      .clk              (clk),
      .reset            (reset),
      .board_valid      (board_valid),
      .board_in         (board_in),
      .white_to_move_in (white_to_move_in),
      .clear_moves      (clear_moves),
      .board            (board),
      .white_to_move    (white_to_move),
      .start            (start),
      .cand_valid       (cand_valid),
      .from_sq          (from_sq),
      .to_sq            (to_sq),
      .piece            (piece),
      .moves_ready      (moves_ready)
   );

   move_builder i_move_builder (
      .clk        (clk),
      .reset      (reset),
      .board      (board),
      .cand_valid (cand_valid),
      .from_sq    (from_sq),
      .to_sq      (to_sq),
      .piece      (piece),
      .wr         (wr),
      .wr_board   (wr_board)
   );

   move_store i_move_store (
      .clk               (clk),
      .reset             (reset),
      .start             (start),
      .wr                (wr),
      .wr_board          (wr_board),
      .white_to_move     (white_to_move),
      .move_index        (move_index),
      .move_count        (move_count),
      .board_out         (board_out),
      .white_to_move_out (white_to_move_out)
   );

endmodule

`default_nettype wire

/* move_store.sv */
`timescale 1ns/100ps
`default_nettype none

module move_store
   import chess_pkg::*;
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        start,
   input  logic                        wr,
   input  board_t                      wr_board,
   input  logic                        white_to_move,
   input  logic [MOVE_INDEX_WIDTH-1:0] move_index,
   output logic [MOVE_COUNT_WIDTH-1:0] move_count,
   output board_t                      board_out,
   output logic                        white_to_move_out
);

   board_t move_mem [MAX_MOVES];
   logic   full;

   assign full = (move_count == MOVE_COUNT_WIDTH'(MAX_MOVES));

   always_ff @(posedge clk)
   begin
      if (reset || start)
         move_count <= '0;
      else if (wr && !full)
         move_count <= move_count + 1'b1; // saturates at MAX_MOVES
   end

   always_ff @(posedge clk)
   begin
      if (wr && !full)
         move_mem[move_count[MOVE_INDEX_WIDTH-1:0]] <= wr_board;
      board_out <= move_mem[move_index];
      white_to_move_out <= ~white_to_move; // opponent moves next
   end

endmodule

`default_nettype wire

/* move_builder.sv */
`timescale 1ns/100ps
`default_nettype none

module move_builder
   import chess_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  board_t                 board,
   input  logic                   cand_valid,
   input  square_t                from_sq,
   input  square_t                to_sq,
   input  logic [PIECE_WIDTH-1:0] piece,
   output logic                   wr,
   output board_t                 wr_board
);

   always_ff @(posedge clk)
   begin
      if (reset)
         wr <= 1'b0;
      else
         wr <= cand_valid;
   end

   // later assignment wins on the target square
   always_ff @(posedge clk)
   begin
      if (cand_valid)
      begin
         wr_board <= board;
         wr_board[from_sq*PIECE_WIDTH +: PIECE_WIDTH] <= '0;
         wr_board[to_sq*PIECE_WIDTH +: PIECE_WIDTH] <= piece;
      end
   end

endmodule

`default_nettype wire

/* move_scan_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module move_scan_fsm
   import chess_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   board_valid,
   input  board_t                 board_in,
   input  logic                   white_to_move_in,
   input  logic                   clear_moves,
   output board_t                 board,
   output logic                   white_to_move,
   output logic                   start,
   output logic                   cand_valid,
   output square_t                from_sq,
   output square_t                to_sq,
   output logic [PIECE_WIDTH-1:0] piece,
   output logic                   moves_ready
);

   scan_state_t            state;
   square_t                sq;
   logic [3:0]             dir;
   coord_t                 row;
   coord_t                 col;
   coord_t                 origin_row;
   coord_t                 origin_col;
   logic                   side_black;
   logic                   target_ok;
   logic                   target_occupied;
   logic [PIECE_WIDTH-1:0] sq_piece;
   piece_t                 sq_kind;
   piece_t                 kind;

   assign side_black = ~white_to_move;
   assign origin_row = coord_t'(sq[5:3]);
   assign origin_col = coord_t'(sq[2:0]);
   assign sq_piece = square_of(board, sq);
   assign sq_kind = piece_t'(sq_piece[2:0]);
   assign kind = piece_t'(piece[2:0]); // piece under move

   assign start = (state == S_IDLE) && board_valid;
   assign cand_valid = ((state == S_SLIDE) || (state == S_STEP)) && target_ok;
   assign from_sq = sq;
   assign to_sq = {row[2:0], col[2:0]};
   assign moves_ready = (state == S_DONE);

   square_probe i_square_probe (
      .board           (board),
      .side_black      (side_black),
      .target_row      (row),
      .target_col      (col),
      .target_ok       (target_ok),
      .target_occupied (target_occupied)
   );

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= S_IDLE;
         sq <= '0;
         dir <= '0;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (board_valid)
               begin
                  board <= board_in;
                  white_to_move <= white_to_move_in;
                  sq <= '0;
                  state <= S_SQUARE;
               end
            end
            S_SQUARE:
            begin
               dir <= '0;
               piece <= sq_piece;
               if (sq_kind == EMPTY || sq_kind == PAWN || sq_kind > KING ||
                   sq_piece[BLACK_BIT] != side_black)
                  state <= S_NEXT; // nothing to move here
               else
                  state <= S_DIR_INIT;
            end
            S_DIR_INIT:
            begin
               if (dir < DIR_COUNT[kind])
               begin
                  row <= origin_row + dir_offset(kind, dir[2:0], 1'b0);
                  col <= origin_col + dir_offset(kind, dir[2:0], 1'b1);
                  if (kind == KNIGHT || kind == KING)
                     state <= S_STEP;
                  else
                     state <= S_SLIDE;
               end
               else
                  state <= S_NEXT;
            end
            S_SLIDE:
            begin
               if (target_ok && !target_occupied)
               begin
                  row <= row + dir_offset(kind, dir[2:0], 1'b0); // keep sliding
                  col <= col + dir_offset(kind, dir[2:0], 1'b1);
               end
               else
               begin
                  dir <= dir + 4'd1; // capture, block or edge
                  state <= S_DIR_INIT;
               end
            end
            S_STEP:
            begin
               dir <= dir + 4'd1;
               state <= S_DIR_INIT;
            end
            S_NEXT:
            begin
               sq <= sq + 6'd1;
               if (sq == 6'd63)
                  state <= S_DONE;
               else
                  state <= S_SQUARE;
            end
            S_DONE:
            begin
               if (clear_moves)
                  state <= S_IDLE;
            end
            default:
               state <= S_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* square_probe.sv */
`timescale 1ns/100ps
`default_nettype none

module square_probe
   import chess_pkg::*;
(
   input  board_t board,
   input  logic   side_black,
   input  coord_t target_row,
   input  coord_t target_col,
   output logic   target_ok,
   output logic   target_occupied
);

   logic                   on_board;
   square_t                target_sq;
   logic [PIECE_WIDTH-1:0] target_piece;

   assign on_board = (target_row >= 0) && (target_row <= 7) &&
                     (target_col >= 0) && (target_col <= 7);

   // low bits are only meaningful when on_board
   assign target_sq = {target_row[2:0], target_col[2:0]};
   assign target_piece = square_of(board, target_sq);

   assign target_occupied = on_board && (target_piece != '0);

   // free square or opponent piece
   assign target_ok = on_board &&
                      (!target_occupied || (target_piece[BLACK_BIT] != side_black));

endmodule

`default_nettype wire

/* chess_pkg.sv */
`default_nettype none

package chess_pkg;

   localparam int PIECE_WIDTH = 4;
   localparam int BOARD_WIDTH = 256;    // 64 squares of PIECE_WIDTH bits
   localparam int BLACK_BIT = 3;
   localparam int MAX_MOVES = 128;
   localparam int MOVE_INDEX_WIDTH = 7;
   localparam int MOVE_COUNT_WIDTH = 8; // must reach MAX_MOVES

   typedef enum logic [2:0] {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_t;

   typedef logic signed [4:0] coord_t;  // row or column, may leave the board
   typedef logic [BOARD_WIDTH-1:0] board_t;
   typedef logic [5:0] square_t;        // row * 8 + col

   typedef enum logic [2:0] {
      S_IDLE,
      S_SQUARE,
      S_DIR_INIT,
      S_SLIDE,
      S_STEP,
      S_NEXT,
      S_DONE
   } scan_state_t;

   // queen and king share the eight neighbours
   localparam coord_t NEIGHBOUR_ROW [8] = '{-1, -1, -1, 0, 0, 1, 1, 1};
   localparam coord_t NEIGHBOUR_COL [8] = '{-1, 0, 1, -1, 1, -1, 0, 1};
   localparam coord_t ROOK_ROW [8] = '{0, 0, 1, -1, 0, 0, 0, 0};
   localparam coord_t ROOK_COL [8] = '{1, -1, 0, 0, 0, 0, 0, 0};
   localparam coord_t BISHOP_ROW [8] = '{1, 1, -1, -1, 0, 0, 0, 0};
   localparam coord_t BISHOP_COL [8] = '{1, -1, 1, -1, 0, 0, 0, 0};
   localparam coord_t KNIGHT_ROW [8] = '{-2, -1, 1, 2, 2, 1, -1, -2};
   localparam coord_t KNIGHT_COL [8] = '{-1, -2, -2, -1, 1, 2, 2, 1};

   // directions per piece type, indexed by piece_t
   localparam logic [3:0] DIR_COUNT [8] = '{0, 0, 8, 4, 4, 8, 8, 0};

   function automatic logic [PIECE_WIDTH-1:0] square_of(board_t board, square_t sq);
      return board[sq*PIECE_WIDTH +: PIECE_WIDTH];
   endfunction

   // row offset, or column offset when want_col is set
   function automatic coord_t dir_offset(piece_t kind, logic [2:0] dir, logic want_col);
      coord_t r;
      coord_t c;
      case (kind)
         KNIGHT:
         begin
            r = KNIGHT_ROW[dir];
            c = KNIGHT_COL[dir];
         end
         ROOK:
         begin
            r = ROOK_ROW[dir];
            c = ROOK_COL[dir];
         end
         BISHOP:
         begin
            r = BISHOP_ROW[dir];
            c = BISHOP_COL[dir];
         end
         default:
         begin
            r = NEIGHBOUR_ROW[dir];
            c = NEIGHBOUR_COL[dir];
         end
      endcase
      return want_col ? c : r;
   endfunction

endpackage

`default_nettype wire
